/* hdl/dcache_pkg.sv */
// Data cache package
// Shared geometry, address fields, vector types and the controller states
package dcache_pkg;

  // ======================================================================
  // Geometry
  // ======================================================================
  localparam int LINES          = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int MEM_WORDS      = 1024;
  localparam int MEM_LATENCY    = 2;

  // Address field positions
  localparam int WORD_LSB  = 2;
  localparam int INDEX_LSB = 4;
  localparam int TAG_LSB   = 9;

  typedef logic [31:0]  word_t;
  typedef logic [127:0] line_t;
  typedef logic [4:0]   index_t;
  typedef logic [22:0]  tag_t;
  typedef logic [15:0]  byte_en_t;
  typedef logic [1:0]   size_t;

  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  typedef enum logic [2:0] {
    IDLE,
    CHK,
    WHIT,
    WMISS,
    RMISS
  } dcache_state_t;

  // Byte lanes of one word touched by a store
  function automatic logic [3:0] word_byte_en(size_t size, logic [1:0] offset);
    case (size)
      SIZE_BYTE: return 4'b0001 << offset;
      SIZE_HALF: return offset[1] ? 4'b1100 : 4'b0011;
      default:   return 4'b1111;
    endcase
  endfunction

endpackage

/* hdl/cache_mem_if.sv */
// Cache to memory link
// Request strobe from the cache, acknowledge pulses and read data back
`timescale 1ns/100ps

interface cache_mem_if;

  logic                 req;
  logic                 write;
  dcache_pkg::word_t    addr;
  dcache_pkg::word_t    wdata;
  dcache_pkg::size_t    size;
  logic                 ack;
  dcache_pkg::word_t    rdata;

  modport cache (
    output req, write, addr, wdata, size,
    input  ack, rdata
  );

  modport memory (
    input  req, write, addr, wdata, size,
    output ack, rdata
  );

endinterface

/* hdl/data_array.sv */
// Cache data array
// One 128-bit line per index, registered read, byte-wise write
`timescale 1ns/100ps

module data_array (
  input  logic                   clk,
  input  dcache_pkg::index_t     index,
  input  logic                   rd_en,
  input  dcache_pkg::byte_en_t   byte_en,
  input  dcache_pkg::line_t      wdata,
  output dcache_pkg::line_t      rdata
);

  dcache_pkg::line_t lines [dcache_pkg::LINES];

  always_ff @(posedge clk) begin
    for (int b = 0; b < $bits(dcache_pkg::byte_en_t); b++) begin
      if (byte_en[b]) begin
        lines[index][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  // Read port holds its value when not enabled
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= lines[index];
    end
  end

endmodule

/* hdl/tag_array.sv */
// Cache tag array
// Tag per line with a registered read, plus the valid bits set on refill
`timescale 1ns/100ps

module tag_array (
  input  logic                 clk,
  input  logic                 rstn,
  input  dcache_pkg::index_t   index,
  input  logic                 rd_en,
  input  logic                 wr_en,
  input  dcache_pkg::tag_t     wtag,
  output dcache_pkg::tag_t     rtag,
  output logic                 valid
);

  dcache_pkg::tag_t           tags [dcache_pkg::LINES];
  logic [dcache_pkg::LINES-1:0] valid_bits;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tags[index] <= wtag;
    end
    if (rd_en) begin
      rtag <= tags[index];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid_bits <= '0;
    end else if (wr_en) begin
      valid_bits[index] <= 1'b1;
    end
  end

  // Looked up in the same cycle as the request
  assign valid = valid_bits[index];

endmodule

/* hdl/l1_dcache.sv */
// L1 data cache controller
// Direct mapped, write-through, no allocate on store miss, with hit/miss counters
`timescale 1ns/100ps

module l1_dcache (
  input  logic                 clk,
  input  logic                 rstn,
  input  dcache_pkg::word_t    core_addr,
  input  logic                 core_req,
  input  logic                 core_write,
  input  dcache_pkg::word_t    core_wdata,
  input  dcache_pkg::size_t    core_size,
  cache_mem_if.cache           mem,
  output dcache_pkg::word_t    core_rdata,
  output logic                 core_wait,
  output dcache_pkg::word_t    load_hits,
  output dcache_pkg::word_t    load_misses,
  output dcache_pkg::word_t    store_hits,
  output dcache_pkg::word_t    store_misses
);

  dcache_pkg::dcache_state_t state, next_state;

  // Captured request
  dcache_pkg::word_t    addr_r;
  dcache_pkg::word_t    wdata_r;
  dcache_pkg::size_t    size_r;
  logic                 write_r;

  dcache_pkg::index_t   index;
  dcache_pkg::tag_t     tag_r;
  dcache_pkg::tag_t     rtag;
  logic                 valid;
  logic                 hit;
  logic [1:0]           word_off;

  dcache_pkg::line_t    da_rdata;
  dcache_pkg::line_t    da_wdata;
  dcache_pkg::byte_en_t da_byte_en;
  dcache_pkg::byte_en_t store_be;
  dcache_pkg::line_t    fill_line;
  logic                 array_rd;

  logic [2:0]           ack_cnt;
  logic                 req_sent;
  logic                 fill_done;
  logic                 store_done;

  // ======================================================================
  // Request capture and state machine
  // ======================================================================
  always_ff @(posedge clk) begin
    if (state == dcache_pkg::IDLE) begin
      addr_r  <= core_addr;
      wdata_r <= core_wdata;
      size_r  <= core_size;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= dcache_pkg::IDLE;
      write_r <= 1'b0;
    end else begin
      state <= next_state;
      if (state == dcache_pkg::IDLE) begin
        write_r <= core_write;
      end
    end
  end

  assign index    = (state == dcache_pkg::IDLE)
                  ? dcache_pkg::index_t'(core_addr >> dcache_pkg::INDEX_LSB)
                  : dcache_pkg::index_t'(addr_r >> dcache_pkg::INDEX_LSB);
  assign tag_r    = dcache_pkg::tag_t'(addr_r >> dcache_pkg::TAG_LSB);
  assign word_off = addr_r[dcache_pkg::WORD_LSB +: 2];
  assign hit      = (state == dcache_pkg::CHK) && (rtag == tag_r);

  assign fill_done  = (ack_cnt == 3'(dcache_pkg::WORDS_PER_LINE));
  assign store_done = (ack_cnt == 3'd1);

  always_comb begin
    next_state = state;
    case (state)
      dcache_pkg::IDLE: begin
        if (core_req && !valid) begin
          next_state = core_write ? dcache_pkg::WMISS : dcache_pkg::RMISS;
        end else if (core_req) begin
          next_state = dcache_pkg::CHK;
        end
      end
      dcache_pkg::CHK: begin
        if (write_r) begin
          next_state = hit ? dcache_pkg::WHIT : dcache_pkg::WMISS;
        end else begin
          next_state = hit ? dcache_pkg::IDLE : dcache_pkg::RMISS;
        end
      end
      dcache_pkg::WHIT,
      dcache_pkg::WMISS: if (store_done) next_state = dcache_pkg::IDLE;
      dcache_pkg::RMISS: if (fill_done) next_state = dcache_pkg::IDLE;
      default: next_state = dcache_pkg::IDLE;
    endcase
  end

  assign core_wait = (state != dcache_pkg::IDLE);

  // ======================================================================
  // Memory transactions
  // ======================================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack_cnt  <= '0;
      req_sent <= 1'b0;
    end else if (state == dcache_pkg::IDLE || state == dcache_pkg::CHK) begin
      ack_cnt  <= '0;
      req_sent <= 1'b0;
    end else begin
      if (mem.ack) ack_cnt <= ack_cnt + 3'd1;
      if (mem.req) req_sent <= 1'b1;
    end
  end

  // One strobe on entry to a memory state
  assign mem.req   = !req_sent && (state == dcache_pkg::WHIT || state == dcache_pkg::WMISS ||
                                   state == dcache_pkg::RMISS);
  assign mem.write = write_r;
  assign mem.addr  = (state == dcache_pkg::RMISS) ? {addr_r[31:4], 4'h0} : addr_r;
  assign mem.wdata = wdata_r;
  assign mem.size  = (state == dcache_pkg::RMISS) ? dcache_pkg::SIZE_WORD : size_r;

  // Refill words arrive lowest first and shift down
  always_ff @(posedge clk) begin
    if (state == dcache_pkg::RMISS && mem.ack) begin
      fill_line <= {mem.rdata, fill_line[127:32]};
    end
  end

  // ======================================================================
  // Arrays
  // ======================================================================
  // Store data is lane aligned, so the word repeats across the line
  assign store_be = {12'h0, dcache_pkg::word_byte_en(size_r, addr_r[1:0])} << {word_off, 2'b00};
  assign array_rd = (state == dcache_pkg::IDLE) && core_req;

  always_comb begin
    da_byte_en = '0;
    da_wdata   = fill_line;
    if (state == dcache_pkg::WHIT && store_done) begin
      da_byte_en = store_be;
      da_wdata   = {4{wdata_r}};
    end else if (state == dcache_pkg::RMISS && fill_done) begin
      da_byte_en = '1;
    end
  end

  data_array u_data (
    .clk     (clk),
    .index   (index),
    .rd_en   (array_rd),
    .byte_en (da_byte_en),
    .wdata   (da_wdata),
    .rdata   (da_rdata)
  );

  tag_array u_tag (
    .clk     (clk),
    .rstn    (rstn),
    .index   (index),
    .rd_en   (array_rd),
    .wr_en   (state == dcache_pkg::RMISS && fill_done),
    .wtag    (tag_r),
    .rtag    (rtag),
    .valid   (valid)
  );

  // Load result and counters
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      core_rdata   <= '0;
      load_hits    <= '0;
      load_misses  <= '0;
      store_hits   <= '0;
      store_misses <= '0;
    end else begin
      if (hit && !write_r) begin
        core_rdata <= da_rdata[{word_off, 5'b0} +: 32];
        load_hits  <= load_hits + 32'd1;
      end
      if (state == dcache_pkg::RMISS && fill_done) begin
        core_rdata  <= fill_line[{word_off, 5'b0} +: 32];
        load_misses <= load_misses + 32'd1;
      end
      if (state == dcache_pkg::WHIT && store_done) store_hits <= store_hits + 32'd1;
      if (state == dcache_pkg::WMISS && store_done) store_misses <= store_misses + 32'd1;
    end
  end

endmodule

/* hdl/main_memory.sv */
// Backing memory model
// Word-wide store with fixed latency, single writes and four-word line reads
`timescale 1ns/100ps

module main_memory (
  input  logic         clk,
  input  logic         rstn,
  cache_mem_if.memory  bus
);

  dcache_pkg::word_t words [dcache_pkg::MEM_WORDS];

  logic       busy;
  logic       is_write;
  logic [1:0] beat;
  logic [3:0] lat_cnt;
  logic       last_beat;
  logic [3:0] lane_en;
  logic [$clog2(dcache_pkg::MEM_WORDS)-1:0] word_idx;

  assign word_idx  = bus.addr[11:2] + 10'(beat);
  assign lane_en   = dcache_pkg::word_byte_en(bus.size, bus.addr[1:0]);
  assign last_beat = is_write || (beat == 2'(dcache_pkg::WORDS_PER_LINE - 1));

  // Ack once the latency count runs out
  assign bus.ack   = busy && (lat_cnt == '0);
  assign bus.rdata = words[word_idx];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy     <= 1'b0;
      is_write <= 1'b0;
      beat     <= '0;
      lat_cnt  <= '0;
      for (int i = 0; i < dcache_pkg::MEM_WORDS; i++) begin
        words[i] <= '0;
      end
    end else if (!busy) begin
      if (bus.req) begin
        busy     <= 1'b1;
        is_write <= bus.write;
        beat     <= '0;
        lat_cnt  <= 4'(dcache_pkg::MEM_LATENCY - 1);
      end
    end else if (lat_cnt != '0) begin
      lat_cnt <= lat_cnt - 4'd1;
    end else begin
      if (is_write) begin
        for (int b = 0; b < 4; b++) begin
          if (lane_en[b]) words[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      busy    <= !last_beat;
      beat    <= beat + 2'd1;
      lat_cnt <= 4'(dcache_pkg::MEM_LATENCY - 1);
    end
  end

endmodule

/* hdl/dcache_top.sv */
// Data cache subsystem
// Cache controller joined to the backing memory model
`timescale 1ns/100ps

module dcache_top (
  input  logic                 clk,
  input  logic                 rstn,
  input  dcache_pkg::word_t    core_addr,
  input  logic                 core_req,
  input  logic                 core_write,
  input  dcache_pkg::word_t    core_wdata,
  input  dcache_pkg::size_t    core_size,
  output dcache_pkg::word_t    core_rdata,
  output logic                 core_wait,
  output dcache_pkg::word_t    load_hits,
  output dcache_pkg::word_t    load_misses,
  output dcache_pkg::word_t    store_hits,
  output dcache_pkg::word_t    store_misses
);

  cache_mem_if mem_bus ();

  l1_dcache cache (
    .clk          (clk),
    .rstn         (rstn),
    .core_addr    (core_addr),
    .core_req     (core_req),
    .core_write   (core_write),
    .core_wdata   (core_wdata),
    .core_size    (core_size),
    .mem          (mem_bus),
    .core_rdata   (core_rdata),
    .core_wait    (core_wait),
    .load_hits    (load_hits),
    .load_misses  (load_misses),
    .store_hits   (store_hits),
    .store_misses (store_misses)
  );

  main_memory mem (
    .clk  (clk),
    .rstn (rstn),
    .bus  (mem_bus)
  );

endmodule

/* test/dcache_asserts.sv */
// Cache controller protocol checks
// Watches the core wait signal and the memory request and acknowledge
`timescale 1ns/100ps

module dcache_asserts (
  input logic                      clk,
  input logic                      rstn,
  input dcache_pkg::dcache_state_t state,
  input logic                      core_wait,
  input logic                      req,
  input logic                      ack,
  input logic                      req_sent
);

  // Core sees an idle cache right after reset
  reset_idle: assert property (@(posedge clk) $rose(rstn) |-> !core_wait)
    else $error("core_wait high in the first cycle after reset release");

  // Memory request is a one-cycle strobe
  req_strobe: assert property (@(posedge clk) disable iff (!rstn)
      req |=> !req)
    else $error("memory request held high for more than one cycle");

  // Every ack answers a strobe already sent
  ack_outstanding: assert property (@(posedge clk) disable iff (!rstn)
      ack |-> (req_sent && state != dcache_pkg::IDLE && state != dcache_pkg::CHK))
    else $error("memory ack without an outstanding transaction");

endmodule

bind l1_dcache dcache_asserts u_asserts (
  .clk       (clk),
  .rstn      (rstn),
  .state     (state),
  .core_wait (core_wait),
  .req       (mem.req),
  .ack       (mem.ack),
  .req_sent  (req_sent)
);

/* test/dcache_tb.sv */
// Data cache testbench
// Random loads and stores checked against a byte memory and tag model
`timescale 1ns/100ps

module dcache_tb;

  localparam int NUM_RANDOM   = 400;
  localparam int NUM_DIRECTED = 29;
  localparam int MAX_CYCLES   = (NUM_RANDOM + NUM_DIRECTED) * 20 + 10;

  logic              clk = 1'b0;
  logic              rstn;
  dcache_pkg::word_t core_addr;
  logic              core_req;
  logic              core_write;
  dcache_pkg::word_t core_wdata;
  dcache_pkg::size_t core_size;
  dcache_pkg::word_t core_rdata;
  logic              core_wait;
  dcache_pkg::word_t load_hits;
  dcache_pkg::word_t load_misses;
  dcache_pkg::word_t store_hits;
  dcache_pkg::word_t store_misses;

  // Reference memory and tag model
  logic [7:0]        ref_mem [4096];
  logic              model_valid [dcache_pkg::LINES];
  dcache_pkg::tag_t  model_tag [dcache_pkg::LINES];
  dcache_pkg::word_t exp_load_hits;
  dcache_pkg::word_t exp_load_misses;
  dcache_pkg::word_t exp_store_hits;
  dcache_pkg::word_t exp_store_misses;

  integer seed = 32'hdc29;
  int     cycles = 0;

  dcache_top dut (
    .clk          (clk),
    .rstn         (rstn),
    .core_addr    (core_addr),
    .core_req     (core_req),
    .core_write   (core_write),
    .core_wdata   (core_wdata),
    .core_size    (core_size),
    .core_rdata   (core_rdata),
    .core_wait    (core_wait),
    .load_hits    (load_hits),
    .load_misses  (load_misses),
    .store_hits   (store_hits),
    .store_misses (store_misses)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Testbench failed");
      $fatal(1, "timeout after %0d cycles, the test sequence did not complete", cycles);
    end
  end

  // ======================================================================
  // Helpers
  // ======================================================================
  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "%s check failed", name);
    end
  endtask

  // Bytes of a word that a store writes
  function automatic logic [3:0] lane_mask(dcache_pkg::size_t size, logic [1:0] offset);
    logic [3:0] mask;
    mask = 4'b0000;
    if (size == dcache_pkg::SIZE_BYTE) begin
      mask[offset] = 1'b1;
    end else if (size == dcache_pkg::SIZE_HALF) begin
      mask[{offset[1], 1'b0}] = 1'b1;
      mask[{offset[1], 1'b1}] = 1'b1;
    end else begin
      mask = 4'b1111;
    end
    return mask;
  endfunction

  function automatic dcache_pkg::word_t model_word(logic [11:0] base);
    return {ref_mem[base | 12'd3], ref_mem[base | 12'd2],
            ref_mem[base | 12'd1], ref_mem[base]};
  endfunction

  // One core access, then the model update and checks
  task automatic access(input logic write, input dcache_pkg::word_t addr,
                        input dcache_pkg::size_t size, input dcache_pkg::word_t wdata);
    dcache_pkg::index_t idx;
    dcache_pkg::tag_t   tag;
    logic               is_hit;
    logic [3:0]         mask;
    logic [11:0]        base;
    int                 waited;
    idx    = addr[8:4];
    tag    = addr[31:9];
    is_hit = model_valid[idx] && (model_tag[idx] == tag);
    mask   = lane_mask(size, addr[1:0]);
    base   = {addr[11:2], 2'b00};
    waited = 0;
    @(posedge clk);
    core_req   <= 1'b1;
    core_write <= write;
    core_addr  <= addr;
    core_size  <= size;
    core_wdata <= wdata;
    @(posedge clk);
    core_req <= 1'b0;
    @(negedge clk);
    while (core_wait) begin
      waited++;
      @(negedge clk);
    end
    if (write) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) ref_mem[base | 12'(b)] = wdata[8*b +: 8];
      end
      if (is_hit) exp_store_hits = exp_store_hits + 32'd1;
      else exp_store_misses = exp_store_misses + 32'd1;
    end else begin
      check("core_rdata", core_rdata, model_word(base));
      if (is_hit) begin
        check("load hit wait cycles", 32'(waited), 32'd1);
        exp_load_hits = exp_load_hits + 32'd1;
      end else begin
        exp_load_misses = exp_load_misses + 32'd1;
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;
      end
    end
    check("load_hits", load_hits, exp_load_hits);
    check("load_misses", load_misses, exp_load_misses);
    check("store_hits", store_hits, exp_store_hits);
    check("store_misses", store_misses, exp_store_misses);
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial begin
    logic [31:0]       r;
    logic [4:0]        line_idx;
    logic [2:0]        tag_bits;
    logic [3:0]        offset;
    dcache_pkg::size_t size;
    rstn       <= 1'b0;
    core_req   <= 1'b0;
    core_write <= 1'b0;
    core_addr  <= '0;
    core_wdata <= '0;
    core_size  <= dcache_pkg::SIZE_WORD;
    for (int i = 0; i < 4096; i++) ref_mem[i] = 8'h00;
    for (int i = 0; i < dcache_pkg::LINES; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    exp_load_hits    = '0;
    exp_load_misses  = '0;
    exp_store_hits   = '0;
    exp_store_misses = '0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check("core_wait", 32'(core_wait), 32'd0);
    check("load_hits", load_hits, 32'd0);
    check("load_misses", load_misses, 32'd0);
    check("store_hits", store_hits, 32'd0);
    check("store_misses", store_misses, 32'd0);

    // Sub-word stores on a cached line and past it
    access(1'b1, 32'h140, dcache_pkg::SIZE_WORD, 32'h1122_3344);
    access(1'b0, 32'h140, dcache_pkg::SIZE_WORD, '0);
    access(1'b1, 32'h141, dcache_pkg::SIZE_BYTE, 32'h0000_aa00);
    access(1'b1, 32'h142, dcache_pkg::SIZE_HALF, 32'hbeef_0000);
    access(1'b0, 32'h140, dcache_pkg::SIZE_WORD, '0);
    access(1'b1, 32'h14b, dcache_pkg::SIZE_BYTE, 32'h5500_0000);
    access(1'b0, 32'h148, dcache_pkg::SIZE_WORD, '0);
    access(1'b1, 32'h340, dcache_pkg::SIZE_WORD, 32'hcafe_f00d);
    access(1'b1, 32'h340, dcache_pkg::SIZE_HALF, 32'h0000_1234);
    access(1'b0, 32'h340, dcache_pkg::SIZE_WORD, '0);
    access(1'b0, 32'h140, dcache_pkg::SIZE_WORD, '0);

    // Same index, different tags, so every load misses
    access(1'b1, 32'h030, dcache_pkg::SIZE_WORD, 32'h0a0a_0a0a);
    access(1'b1, 32'h830, dcache_pkg::SIZE_WORD, 32'h0b0b_0b0b);
    for (int k = 0; k < 8; k++) begin
      access(1'b0, 32'h030, dcache_pkg::SIZE_WORD, '0);
      access(1'b0, 32'h830, dcache_pkg::SIZE_WORD, '0);
    end

    // Tags and indexes skewed low so that lines get reused
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r        = $random(seed);
      line_idx = r[18] ? r[12:8] : {3'b000, r[9:8]};
      tag_bits = r[2:0] & (r[3] ? 3'b001 : 3'b111);
      offset   = r[17:14];
      size     = (r[5:4] == 2'd3) ? dcache_pkg::SIZE_WORD : r[5:4];
      if (size == dcache_pkg::SIZE_HALF) offset[0] = 1'b0;
      if (size == dcache_pkg::SIZE_WORD) offset[1:0] = 2'b00;
      access(r[20], {20'h0, tag_bits, line_idx, offset}, size, $random(seed));
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

/* dcache.f */
hdl/dcache_pkg.sv
hdl/cache_mem_if.sv
hdl/data_array.sv
hdl/tag_array.sv
hdl/l1_dcache.sv
hdl/main_memory.sv
hdl/dcache_top.sv
test/dcache_asserts.sv
test/dcache_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := dcache_tb
FILELIST   := dcache.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
